// File: Bender.yml
package:
  name: alu_polar

sources:
  - include_dirs:
      - src
    files:
      - src/alu_pkg.sv
      - src/alu_int_unit.sv
      - src/alu_polar_unit.sv
      - src/alu_polar.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/alu_polar_chk.sv
      - verif/alu_polar_tb.sv

// File: alu_polar.f
+incdir+src
src/alu_pkg.sv
src/alu_int_unit.sv
src/alu_polar_unit.sv
src/alu_polar.sv
verif/alu_polar_chk.sv
verif/alu_polar_tb.sv

// File: src/alu_cfg.svh
/*
 * ALU configuration
 * Datapath width, polar lane geometry and shift-amount width.
 */

`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Integer datapath width
`define ALU_XLEN 32

// Polar SIMD lanes, LANE_W * LANES must equal XLEN
`define ALU_LANE_W 8
`define ALU_LANES 4

// Operand B bits used as shift amount
`define ALU_SHAMT_W 5

`endif

// File: src/alu_int_unit.sv
/*
 * Integer datapath
 * Adder, logic, shifter and set-less-than with branch resolution.
 * Returns zero for operations outside the integer class.
 */

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_int_unit import alu_pkg::*; (
    input  alu_op_e                 op_i,
    input  simd_word_u              operand_a_i,
    input  simd_word_u              operand_b_i,
    output logic [`ALU_XLEN-1:0]    int_result_o,
    output logic                    branch_o
);

    logic [`ALU_XLEN-1:0]       op_a;
    logic [`ALU_XLEN-1:0]       op_b;

    logic                       negate_b;
    logic [`ALU_XLEN-1:0]       b_neg;
    logic [`ALU_XLEN:0]         adder_in_a;
    logic [`ALU_XLEN:0]         adder_in_b;
    logic [`ALU_XLEN:0]         adder_sum;
    logic [`ALU_XLEN-1:0]       adder_result;
    logic                       zero_flag;

    logic                       shift_left;
    logic                       shift_arith;
    logic [`ALU_SHAMT_W-1:0]    shift_amt;
    logic [`ALU_XLEN-1:0]       op_a_rev;
    logic [`ALU_XLEN-1:0]       shift_in;
    logic [`ALU_XLEN:0]         shift_in_ext;
    logic [`ALU_XLEN:0]         shift_right_res;
    logic [`ALU_XLEN-1:0]       shift_left_res;
    logic [`ALU_XLEN-1:0]       shift_res;

    logic                       cmp_signed;
    logic                       less;

    assign op_a = operand_a_i.flat;
    assign op_b = operand_b_i.flat;

    // ------------------------------
    // Adder
    // ------------------------------
    always_comb begin
        negate_b = 1'b0;
        case (op_i)
            SUB, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
            default: negate_b = 1'b0;
        endcase
    end

    assign b_neg = op_b ^ {`ALU_XLEN{negate_b}};

    // Extra low bit carries the +1 of the two's complement
    assign adder_in_a   = {op_a, 1'b1};
    assign adder_in_b   = {b_neg, negate_b};
    assign adder_sum    = adder_in_a + adder_in_b;
    assign adder_result = adder_sum[`ALU_XLEN:1];
    assign zero_flag    = ~|adder_result;

    // ------------------------------
    // Shifter
    // ------------------------------
    assign shift_left  = (op_i == SLL);
    assign shift_arith = (op_i == SRA);
    assign shift_amt   = op_b[`ALU_SHAMT_W-1:0];

    // Left shift runs through the right shifter on reversed bits
    for (genvar k = 0; k < `ALU_XLEN; k++) begin : g_rev
        assign op_a_rev[k]       = op_a[`ALU_XLEN-1-k];
        assign shift_left_res[k] = shift_right_res[`ALU_XLEN-1-k];
    end

    assign shift_in        = shift_left ? op_a_rev : op_a;
    assign shift_in_ext    = {shift_arith & shift_in[`ALU_XLEN-1], shift_in};
    assign shift_right_res = $unsigned($signed(shift_in_ext) >>> shift_amt);
    assign shift_res       = shift_left ? shift_left_res : shift_right_res[`ALU_XLEN-1:0];

    // ------------------------------
    // Comparison
    // ------------------------------
    assign cmp_signed = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);

    // One extra sign bit turns the unsigned case into a signed compare
    assign less = $signed({cmp_signed & op_a[`ALU_XLEN-1], op_a}) <
                  $signed({cmp_signed & op_b[`ALU_XLEN-1], op_b});

    always_comb begin
        case (op_i)
            EQ:       branch_o = zero_flag;
            NE:       branch_o = ~zero_flag;
            LTS, LTU: branch_o = less;
            GES, GEU: branch_o = ~less;
            default:  branch_o = 1'b1;
        endcase
    end

    // ------------------------------
    // Result select
    // ------------------------------
    always_comb begin
        case (op_i)
            ADD, SUB:      int_result_o = adder_result;
            ANDL, ANDN:    int_result_o = op_a & b_neg;
            ORL, ORN:      int_result_o = op_a | b_neg;
            XORL, XNOR:    int_result_o = op_a ^ b_neg;
            SLL, SRL, SRA: int_result_o = shift_res;
            SLTS, SLTU:    int_result_o = {{(`ALU_XLEN-1){1'b0}}, less};
            // Branches and polar operations
            default:       int_result_o = '0;
        endcase
    end

endmodule

// File: src/alu_pkg.sv
/*
 * ALU package
 * Operation encoding and the SIMD word type shared by both units.
 */

`include "alu_cfg.svh"

package alu_pkg;

    // ------------------------------
    // Operation codes
    // ------------------------------
    typedef enum logic [4:0] {
        // Adder
        ADD,
        SUB,
        // Logic, plain and negated operand B
        ANDL,
        ORL,
        XORL,
        ANDN,
        ORN,
        XNOR,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set-less-than
        SLTS,
        SLTU,
        // Branch comparisons
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Polar decoding lanes
        PL_F,
        PL_G,
        PL_R,
        PL_DECODE,
        PL_EVAL
    } alu_op_e;

    // ------------------------------
    // SIMD word
    // ------------------------------
    // Signed lane element, keeps its sign when selected from the array
    typedef logic signed [`ALU_LANE_W-1:0] lane_t;

    // Flat view for the integer unit, lane view for the polar unit
    typedef union packed {
        logic [`ALU_XLEN-1:0]         flat;
        lane_t [`ALU_LANES-1:0]       lane;
    } simd_word_u;

endpackage

// File: src/alu_polar.sv
/*
 * ALU with polar SIMD extension
 * Merges integer and polar unit results into one registered output
 * stage with valid/ready handshakes on input and output.
 */

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_polar import alu_pkg::*; (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // Request side
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  alu_op_e                 op_i,
    input  logic [`ALU_XLEN-1:0]    operand_a_i,
    input  logic [`ALU_XLEN-1:0]    operand_b_i,
    input  logic [`ALU_XLEN-1:0]    imm_i,

    // Result side
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output logic [`ALU_XLEN-1:0]    result_o,
    output logic                    branch_o
);

    simd_word_u             a_word;
    simd_word_u             b_word;
    simd_word_u             imm_word;

    logic [`ALU_XLEN-1:0]   int_result;
    logic [`ALU_XLEN-1:0]   polar_result;
    logic                   int_branch;
    logic                   accept;

    logic                   out_valid_q;
    logic [`ALU_XLEN-1:0]   result_q;
    logic                   branch_q;

    assign a_word   = simd_word_u'(operand_a_i);
    assign b_word   = simd_word_u'(operand_b_i);
    assign imm_word = simd_word_u'(imm_i);

    // ------------------------------
    // Units
    // ------------------------------
    alu_int_unit u_int (
        .op_i         (op_i),
        .operand_a_i  (a_word),
        .operand_b_i  (b_word),
        .int_result_o (int_result),
        .branch_o     (int_branch)
    );

    alu_polar_unit u_polar (
        .op_i           (op_i),
        .operand_a_i    (a_word),
        .operand_b_i    (b_word),
        .imm_i          (imm_word),
        .polar_result_o (polar_result)
    );

    // ------------------------------
    // Output stage
    // ------------------------------
    // Register frees up in the same cycle it drains
    assign in_ready_o = ~out_valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_q <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_q <= in_valid_i;
        end
    end

    // Each unit zeroes the other's class, so OR merges them
    always_ff @(posedge clk_i) begin
        if (accept) begin
            result_q <= int_result | polar_result;
            branch_q <= int_branch;
        end
    end

    assign out_valid_o = out_valid_q;
    assign result_o    = result_q;
    assign branch_o    = branch_q;

endmodule

// File: src/alu_polar_unit.sv
/*
 * Polar lane array
 * Four 8-bit lanes for polar-code decoding steps, wrapping arithmetic.
 * Returns zero for non-polar operations.
 */

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_polar_unit import alu_pkg::*; (
    input  alu_op_e                 op_i,
    input  simd_word_u              operand_a_i,
    input  simd_word_u              operand_b_i,
    input  simd_word_u              imm_i,
    output logic [`ALU_XLEN-1:0]    polar_result_o
);

    // Per-operation lane results
    lane_t [`ALU_LANES-1:0] f_res;
    lane_t [`ALU_LANES-1:0] g_res;
    lane_t [`ALU_LANES-1:0] r_res;
    lane_t [`ALU_LANES-1:0] dec_res;
    lane_t [`ALU_LANES-1:0] eval_res;

    // ------------------------------
    // Lanes
    // ------------------------------
    for (genvar i = 0; i < `ALU_LANES; i++) begin : g_lane
        lane_t                    a_l;
        lane_t                    b_l;
        lane_t                    imm_l;
        logic [`ALU_LANE_W-1:0]   abs_a;
        logic [`ALU_LANE_W-1:0]   abs_b;
        logic [`ALU_LANE_W-1:0]   min_mag;
        logic                     sign_diff;

        assign a_l   = operand_a_i.lane[i];
        assign b_l   = operand_b_i.lane[i];
        assign imm_l = imm_i.lane[i];

        // Magnitudes compared unsigned, so -128 maps to 0x80
        assign abs_a     = a_l[`ALU_LANE_W-1] ? -a_l : a_l;
        assign abs_b     = b_l[`ALU_LANE_W-1] ? -b_l : b_l;
        assign sign_diff = a_l[`ALU_LANE_W-1] ^ b_l[`ALU_LANE_W-1];

        // Min-sum check node, ties keep |a|
        assign min_mag    = (abs_a > abs_b) ? abs_b : abs_a;
        assign f_res[i]   = sign_diff ? -min_mag : min_mag;

        // Variable node, imm lane picks the partial-sum sign
        assign g_res[i]   = (imm_l == '0) ? (a_l + b_l) : (a_l - b_l);

        assign r_res[i]   = (a_l[`ALU_LANE_W-1] && (b_l != 1)) ?
                            {{(`ALU_LANE_W-1){1'b0}}, 1'b1} : '0;

        // Pass a through only on frozen (zero) b
        assign dec_res[i]  = (b_l == '0) ? a_l : '0;
        assign eval_res[i] = (a_l == 1) ? '1 : '0;
    end

    // ------------------------------
    // Operation select
    // ------------------------------
    always_comb begin
        case (op_i)
            PL_F:      polar_result_o = f_res;
            PL_G:      polar_result_o = g_res;
            PL_R:      polar_result_o = r_res;
            PL_DECODE: polar_result_o = dec_res;
            PL_EVAL:   polar_result_o = eval_res;
            default:   polar_result_o = '0;
        endcase
    end

endmodule

// File: verif/alu_polar_chk.sv
/*
 * Handshake checker for the ALU output stage
 * Bound into alu_polar, watches reset, stall stability and the ready rule.
 */

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_polar_chk (
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 in_ready_o,
    input logic                 out_valid_o,
    input logic                 out_ready_i,
    input logic [`ALU_XLEN-1:0] result_o,
    input logic                 branch_o
);

    int unsigned fail_count = 0;

    // Output register empty right after reset
    a_reset_clear: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
        else begin
            $error("out_valid_o high in the cycle after reset");
            fail_count++;
        end

    // Held result must not move while the consumer stalls
    a_stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> $stable(result_o) && $stable(branch_o))
        else begin
            $error("result_o or branch_o changed while stalled");
            fail_count++;
        end

    a_ready_rule: assert property (@(posedge clk_i) disable iff (reset_i)
        in_ready_o == (!out_valid_o || out_ready_i))
        else begin
            $error("in_ready_o does not follow out_valid_o and out_ready_i");
            fail_count++;
        end

endmodule

bind alu_polar alu_polar_chk u_chk (.*);

// File: verif/alu_polar_tb.sv
/*
 * ALU testbench
 * Directed tests of the integer and polar operations against a
 * reference model, including output back-pressure.
 */

`timescale 1ns/1ps

`include "alu_cfg.svh"

module alu_polar_tb import alu_pkg::*; ();

    localparam int clk_period     = 20;
    // Bound on operations issued over all tests
    localparam int max_ops        = 250;
    localparam int timeout_cycles = max_ops * 40 + 100;

    logic                   clk_i;
    logic                   reset_i;
    logic                   in_valid_i;
    logic                   in_ready_o;
    alu_op_e                op_i;
    logic [`ALU_XLEN-1:0]   operand_a_i;
    logic [`ALU_XLEN-1:0]   operand_b_i;
    logic [`ALU_XLEN-1:0]   imm_i;
    logic                   out_valid_o;
    logic                   out_ready_i;
    logic [`ALU_XLEN-1:0]   result_o;
    logic                   branch_o;

    int                     errors;
    int                     op_count;
    logic [31:0]            rng_state;

    alu_polar dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    initial begin
        #(timeout_cycles * clk_period);
        $display("Watchdog expired, the tests did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [7:0] model_lane(alu_op_e op, logic [7:0] a, logic [7:0] b,
                                              logic [7:0] imm);
        logic [7:0] mag_a;
        logic [7:0] mag_b;
        logic [7:0] m;
        mag_a = a[7] ? 8'd0 - a : a;
        mag_b = b[7] ? 8'd0 - b : b;
        m     = (mag_b < mag_a) ? mag_b : mag_a;
        case (op)
            PL_F:      return (a[7] != b[7]) ? 8'd0 - m : m;
            PL_G:      return (imm == 8'd0) ? a + b : a - b;
            PL_R:      return (a[7] && b != 8'd1) ? 8'd1 : 8'd0;
            PL_DECODE: return (b == 8'd0) ? a : 8'd0;
            PL_EVAL:   return (a == 8'd1) ? 8'hFF : 8'd0;
            default:   return 8'd0;
        endcase
    endfunction

    // Result in the low word and branch flag on top
    function automatic logic [32:0] model_op(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                             logic [31:0] imm);
        logic [31:0] r;
        logic        br;
        r  = 32'd0;
        br = 1'b1;
        case (op)
            ADD:  r = a + b;
            SUB:  r = a - b;
            ANDL: r = a & b;
            ORL:  r = a | b;
            XORL: r = a ^ b;
            ANDN: r = a & ~b;
            ORN:  r = a | ~b;
            XNOR: r = ~(a ^ b);
            SLL:  r = a << b[4:0];
            SRL:  r = a >> b[4:0];
            SRA:  r = $signed(a) >>> b[4:0];
            SLTS: r = {31'd0, $signed(a) < $signed(b)};
            SLTU: r = {31'd0, a < b};
            EQ:   br = (a == b);
            NE:   br = (a != b);
            LTS:  br = ($signed(a) < $signed(b));
            LTU:  br = (a < b);
            GES:  br = ($signed(a) >= $signed(b));
            GEU:  br = (a >= b);
            default: begin
                // Polar operations lane by lane
                for (int k = 0; k < `ALU_LANES; k++)
                    r[8*k +: 8] = model_lane(op, a[8*k +: 8], b[8*k +: 8], imm[8*k +: 8]);
            end
        endcase
        return {br, r};
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // ------------------------------
    // Driver and checks
    // ------------------------------
    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
        errors++;
    endtask

    task automatic drive_input(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] imm);
        in_valid_i  = 1'b1;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
        imm_i       = imm;
    endtask

    task automatic run_op(input string test_name, input alu_op_e op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] imm);
        logic [32:0] expected;
        int          waited;
        expected = model_op(op, a, b, imm);
        waited   = 0;
        @(negedge clk_i);
        drive_input(op, a, b, imm);
        #1;
        while (!in_ready_o && waited < 20) begin
            @(negedge clk_i);
            #1;
            waited++;
        end
        if (!in_ready_o) begin
            $display("%s: in_ready_o stayed low, %s was never accepted", test_name, op.name());
            errors++;
        end
        // Accepted on the rising edge with the result due one cycle later
        @(negedge clk_i);
        in_valid_i = 1'b0;
        op_count++;
        #1;
        if (!out_valid_o) begin
            $display("%s: no result one cycle after %s was accepted", test_name, op.name());
            errors++;
        end
        if (result_o !== expected[31:0])
            report_mismatch(test_name, {op.name(), " result"}, expected[31:0], result_o);
        if (branch_o !== expected[32])
            report_mismatch(test_name, {op.name(), " branch"}, expected[32], branch_o);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic reset_behavior();
        for (int c = 0; c < 4; c++) begin
            @(negedge clk_i);
            if (out_valid_o !== 1'b0)
                report_mismatch("reset", "out_valid_o", 32'd0, out_valid_o);
            if (in_ready_o !== 1'b1)
                report_mismatch("reset", "in_ready_o", 32'd1, in_ready_o);
            // Release after three rising edges
            if (c == 2)
                reset_i = 1'b0;
        end
        out_ready_i = 1'b1;
    endtask

    task automatic arith_logic_ops();
        alu_op_e ops[8];
        ops = '{ADD, SUB, ANDL, ORL, XORL, ANDN, ORN, XNOR};
        foreach (ops[i]) begin
            repeat (6) run_op("arith_logic", ops[i], next_random(), next_random(), 32'd0);
        end
    endtask

    task automatic shift_compare_ops();
        alu_op_e     shift_ops[3];
        alu_op_e     cmp_ops[8];
        logic [31:0] cmp_a[5];
        logic [31:0] cmp_b[5];
        logic [31:0] a;
        logic [31:0] b;
        shift_ops = '{SLL, SRL, SRA};
        cmp_ops   = '{SLTS, SLTU, EQ, NE, LTS, LTU, GES, GEU};
        // Order differs between signed and unsigned in the first four pairs
        cmp_a = '{32'hFFFF_FFFF, 32'h0000_0001, 32'h8000_0000, 32'h7FFF_FFFF, 32'h1234_5678};
        cmp_b = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000, 32'h1234_5678};
        foreach (shift_ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                a     = next_random();
                a[31] = k[0];
                // Upper bits of b are junk the shifter must ignore
                b = next_random();
                if (k == 0)
                    b[4:0] = 5'd0;
                if (k == 1)
                    b[4:0] = 5'd31;
                run_op("shift", shift_ops[i], a, b, 32'd0);
            end
        end
        foreach (cmp_ops[i]) begin
            foreach (cmp_a[k]) run_op("compare_branch", cmp_ops[i], cmp_a[k], cmp_b[k], 32'd0);
        end
    endtask

    task automatic sweep_lanes(input string test_name, input alu_op_e op);
        logic [7:0]  vals[5];
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        vals = '{8'h80, 8'hFF, 8'h00, 8'h01, 8'h7F};
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                // Lane 0 walks every pair while upper lanes rotate the pattern
                for (int k = 0; k < `ALU_LANES; k++) begin
                    a[8*k +: 8]   = vals[(i + k) % 5];
                    b[8*k +: 8]   = vals[(j + 3*k) % 5];
                    imm[8*k +: 8] = ((i + j + k) % 2 == 0) ? 8'h00 : 8'h81;
                end
                run_op(test_name, op, a, b, imm);
            end
        end
    endtask

    task automatic polar_fgr_lanes();
        sweep_lanes("polar_fgr", PL_F);
        sweep_lanes("polar_fgr", PL_G);
        sweep_lanes("polar_fgr", PL_R);
    endtask

    task automatic decode_eval_lanes();
        sweep_lanes("decode_eval", PL_DECODE);
        sweep_lanes("decode_eval", PL_EVAL);
    endtask

    task automatic backpressure_hold();
        logic [32:0] exp1;
        logic [32:0] exp2;
        exp1 = model_op(SUB, 32'h0000_1000, 32'h0000_0001, 32'd0);
        exp2 = model_op(PL_G, 32'h7F01_FF80, 32'h0101_0101, 32'h0000_FF00);
        @(negedge clk_i);
        out_ready_i = 1'b0;
        drive_input(SUB, 32'h0000_1000, 32'h0000_0001, 32'd0);
        // Second input queued behind the held result
        @(negedge clk_i);
        drive_input(PL_G, 32'h7F01_FF80, 32'h0101_0101, 32'h0000_FF00);
        repeat (4) begin
            #1;
            if (in_ready_o !== 1'b0)
                report_mismatch("backpressure", "in_ready_o", 32'd0, in_ready_o);
            if (out_valid_o !== 1'b1 || result_o !== exp1[31:0])
                report_mismatch("backpressure", "held result", exp1[31:0], result_o);
            if (branch_o !== exp1[32])
                report_mismatch("backpressure", "held branch", exp1[32], branch_o);
            @(negedge clk_i);
        end
        // First result drains while the queued input is taken
        out_ready_i = 1'b1;
        @(negedge clk_i);
        in_valid_i = 1'b0;
        #1;
        if (out_valid_o !== 1'b1 || result_o !== exp2[31:0])
            report_mismatch("backpressure", "second result", exp2[31:0], result_o);
        if (branch_o !== exp2[32])
            report_mismatch("backpressure", "second branch", exp2[32], branch_o);
        @(negedge clk_i);
        #1;
        if (out_valid_o !== 1'b0)
            report_mismatch("backpressure", "out_valid_o after drain", 32'd0, out_valid_o);
        op_count += 2;
    endtask

    initial begin
        rng_state   = 32'd71;
        errors      = 0;
        op_count    = 0;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        op_i        = ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        imm_i       = '0;
        out_ready_i = 1'b0;
        reset_behavior();
        arith_logic_ops();
        shift_compare_ops();
        polar_fgr_lanes();
        decode_eval_lanes();
        backpressure_hold();
        $display("Operations: %0d, errors: %0d, assertion failures: %0d",
                 op_count, errors, dut.u_chk.fail_count);
        errors += dut.u_chk.fail_count;
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
